// ==== verilog/sb_pkg.sv ====
package sb_pkg;

    // buffer geometry
    localparam int SB_SIZE  = 4;
    localparam int SB_PTR_W = 2;
    localparam int SB_CNT_W = 3;

    // store payload widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = 4;

    // one buffered store
    // valid marks an occupied slot, commit marks a retired store
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              valid;
        logic              commit;
    } sb_entry_t;

endpackage

// ==== verilog/mem_pkg.sv ====
package mem_pkg;

    // drain gap field width
    localparam int GAP_W = 4;

    // config word width, write and readback
    localparam int CFG_W = 16;

    // config word layout
    localparam int CFG_EN_BIT  = 0;
    localparam int CFG_GAP_LSB = 4;
    // occupancy shows up in the readback only
    localparam int CFG_CNT_LSB = 8;

    // drain enabled, gap of zero
    localparam logic [CFG_W-1:0] CFG_RESET = 16'h0001;

endpackage

// ==== verilog/sb_drain_if.sv ====
`timescale 1ns/1ps

interface sb_drain_if;

    // oldest committed entry, offered to the drain engine
    logic                      valid;
    logic                      ready;
    logic [sb_pkg::ADDR_W-1:0] addr;
    logic [sb_pkg::DATA_W-1:0] data;
    logic [sb_pkg::STRB_W-1:0] strb;

    modport buffer (
        output valid,
        output addr,
        output data,
        output strb,
        input  ready
    );

    modport drain (
        input  valid,
        input  addr,
        input  data,
        input  strb,
        output ready
    );

endinterface

// ==== verilog/store_buffer.sv ====
`timescale 1ns/1ps

module store_buffer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        flush_i,
    input  logic                        commit_i,
    input  logic                        st_valid_i,
    output logic                        st_ready_o,
    input  logic [sb_pkg::ADDR_W-1:0]   st_addr_i,
    input  logic [sb_pkg::DATA_W-1:0]   st_data_i,
    input  logic [sb_pkg::STRB_W-1:0]   st_strb_i,
    output logic [sb_pkg::SB_CNT_W-1:0] sb_count_o,
    sb_drain_if.buffer                  drain
);

    sb_pkg::sb_entry_t entries [sb_pkg::SB_SIZE];

    // head = next free slot, cmt_ptr = oldest uncommitted, tail = oldest
    logic [sb_pkg::SB_PTR_W-1:0] head_q;
    logic [sb_pkg::SB_PTR_W-1:0] cmt_ptr_q;
    logic [sb_pkg::SB_PTR_W-1:0] tail_q;
    logic [sb_pkg::SB_CNT_W-1:0] cnt_q;
    logic [sb_pkg::SB_CNT_W-1:0] cmt_cnt_q;
    logic [sb_pkg::SB_CNT_W-1:0] cnt_d;
    logic [sb_pkg::SB_CNT_W-1:0] cmt_cnt_d;
    logic                        push;
    logic                        pop;
    logic                        do_commit;

    assign push = st_valid_i & st_ready_o & ~flush_i;
    assign pop  = drain.valid & drain.ready;
    // only retire when something is still uncommitted
    assign do_commit = commit_i & ~flush_i & (cnt_q != cmt_cnt_q);

    always_comb begin
        cmt_cnt_d = cmt_cnt_q;
        if (do_commit && !pop) begin
            cmt_cnt_d = cmt_cnt_q + 1;
        end else if (pop && !do_commit) begin
            cmt_cnt_d = cmt_cnt_q - 1;
        end

        cnt_d = cnt_q;
        if (flush_i) begin
            // only committed stores survive a flush
            cnt_d = cmt_cnt_d;
        end else if (push && !pop) begin
            cnt_d = cnt_q + 1;
        end else if (pop && !push) begin
            cnt_d = cnt_q - 1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head_q     <= '0;
            cmt_ptr_q  <= '0;
            tail_q     <= '0;
            cnt_q      <= '0;
            cmt_cnt_q  <= '0;
            st_ready_o <= 1'b1;
        end else begin
            cnt_q      <= cnt_d;
            cmt_cnt_q  <= cmt_cnt_d;
            st_ready_o <= (cnt_d < sb_pkg::SB_SIZE);
            if (pop) begin
                tail_q <= tail_q + 1;
            end
            if (do_commit) begin
                cmt_ptr_q <= cmt_ptr_q + 1;
            end
            // tail plus committed count is always the commit pointer
            if (flush_i) begin
                head_q <= cmt_ptr_q;
            end else if (push) begin
                head_q <= head_q + 1;
            end
        end
    end

    // slot updates, payload is written only on push
    always_ff @(posedge clk) begin
        for (int i = 0; i < sb_pkg::SB_SIZE; i++) begin
            if (!rst_n) begin
                entries[i].valid  <= 1'b0;
                entries[i].commit <= 1'b0;
            end else if (pop && (tail_q == i[sb_pkg::SB_PTR_W-1:0])) begin
                entries[i].valid  <= 1'b0;
                entries[i].commit <= 1'b0;
            end else if (flush_i) begin
                if (!entries[i].commit) begin
                    entries[i].valid <= 1'b0;
                end
            end else begin
                if (push && (head_q == i[sb_pkg::SB_PTR_W-1:0])) begin
                    entries[i].addr   <= st_addr_i;
                    entries[i].data   <= st_data_i;
                    entries[i].strb   <= st_strb_i;
                    entries[i].valid  <= 1'b1;
                    entries[i].commit <= 1'b0;
                end
                if (do_commit && (cmt_ptr_q == i[sb_pkg::SB_PTR_W-1:0])) begin
                    entries[i].commit <= 1'b1;
                end
            end
        end
    end

    // oldest entry goes out once it is committed
    assign drain.valid = entries[tail_q].valid & entries[tail_q].commit;
    assign drain.addr  = entries[tail_q].addr;
    assign drain.data  = entries[tail_q].data;
    assign drain.strb  = entries[tail_q].strb;

    assign sb_count_o = cnt_q;

endmodule

// ==== verilog/sb_drain.sv ====
`timescale 1ns/1ps

module sb_drain (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       drain_en_i,
    input  logic [mem_pkg::GAP_W-1:0]  drain_gap_i,
    sb_drain_if.drain                  entry,
    output logic                       mem_req_o,
    input  logic                       mem_ack_i,
    output logic [sb_pkg::ADDR_W-1:0]  mem_addr_o,
    output logic [sb_pkg::DATA_W-1:0]  mem_data_o,
    output logic [sb_pkg::STRB_W-1:0]  mem_strb_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_REL,
        ST_GAP
    } state_t;

    state_t                    state_q;
    logic [mem_pkg::GAP_W-1:0] gap_q;
    logic                      take;

    assign entry.ready = (state_q == ST_IDLE) & drain_en_i & (gap_q == '0);
    assign take        = entry.valid & entry.ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= ST_IDLE;
            mem_req_o <= 1'b0;
            gap_q     <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (take) begin
                        mem_req_o <= 1'b1;
                        state_q   <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    // hold req until the memory acks
                    if (mem_ack_i) begin
                        mem_req_o <= 1'b0;
                        state_q   <= ST_REL;
                    end
                end
                ST_REL: begin
                    // wait for ack release, then start the idle gap
                    if (!mem_ack_i) begin
                        gap_q   <= drain_gap_i;
                        state_q <= ST_GAP;
                    end
                end
                default: begin
                    if (gap_q == '0) begin
                        state_q <= ST_IDLE;
                    end else begin
                        gap_q <= gap_q - 1;
                    end
                end
            endcase
        end
    end

    // write payload held steady for the whole request
    always_ff @(posedge clk) begin
        if (take) begin
            mem_addr_o <= entry.addr;
            mem_data_o <= entry.data;
            mem_strb_o <= entry.strb;
        end
    end

endmodule

// ==== verilog/sb_config.sv ====
`timescale 1ns/1ps

module sb_config (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        cfg_we_i,
    input  logic [mem_pkg::CFG_W-1:0]   cfg_wdata_i,
    input  logic [sb_pkg::SB_CNT_W-1:0] sb_count_i,
    output logic [mem_pkg::CFG_W-1:0]   cfg_rdata_o,
    output logic                        drain_en_o,
    output logic [mem_pkg::GAP_W-1:0]   drain_gap_o
);

    logic                      drain_en_q;
    logic [mem_pkg::GAP_W-1:0] gap_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            drain_en_q <= mem_pkg::CFG_RESET[mem_pkg::CFG_EN_BIT];
            gap_q      <= mem_pkg::CFG_RESET[mem_pkg::CFG_GAP_LSB +: mem_pkg::GAP_W];
        end else if (cfg_we_i) begin
            drain_en_q <= cfg_wdata_i[mem_pkg::CFG_EN_BIT];
            gap_q      <= cfg_wdata_i[mem_pkg::CFG_GAP_LSB +: mem_pkg::GAP_W];
        end
    end

    assign drain_en_o  = drain_en_q;
    assign drain_gap_o = gap_q;

    // readback, fields plus live occupancy, unused bits read zero
    always_comb begin
        cfg_rdata_o                                            = '0;
        cfg_rdata_o[mem_pkg::CFG_EN_BIT]                       = drain_en_q;
        cfg_rdata_o[mem_pkg::CFG_GAP_LSB +: mem_pkg::GAP_W]    = gap_q;
        cfg_rdata_o[mem_pkg::CFG_CNT_LSB +: sb_pkg::SB_CNT_W]  = sb_count_i;
    end

endmodule

// ==== verilog/lsu_store_top.sv ====
`timescale 1ns/1ps

module lsu_store_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        flush_i,
    input  logic                        commit_i,
    input  logic                        st_valid_i,
    output logic                        st_ready_o,
    input  logic [sb_pkg::ADDR_W-1:0]   st_addr_i,
    input  logic [sb_pkg::DATA_W-1:0]   st_data_i,
    input  logic [sb_pkg::STRB_W-1:0]   st_strb_i,
    output logic                        mem_req_o,
    input  logic                        mem_ack_i,
    output logic [sb_pkg::ADDR_W-1:0]   mem_addr_o,
    output logic [sb_pkg::DATA_W-1:0]   mem_data_o,
    output logic [sb_pkg::STRB_W-1:0]   mem_strb_o,
    input  logic                        cfg_we_i,
    input  logic [mem_pkg::CFG_W-1:0]   cfg_wdata_i,
    output logic [mem_pkg::CFG_W-1:0]   cfg_rdata_o,
    output logic [sb_pkg::SB_CNT_W-1:0] sb_count_o
);

    logic                      drain_en;
    logic [mem_pkg::GAP_W-1:0] drain_gap;

    // buffer to drain engine
    sb_drain_if drain_bus ();

    store_buffer store_buffer_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush_i    (flush_i),
        .commit_i   (commit_i),
        .st_valid_i (st_valid_i),
        .st_ready_o (st_ready_o),
        .st_addr_i  (st_addr_i),
        .st_data_i  (st_data_i),
        .st_strb_i  (st_strb_i),
        .sb_count_o (sb_count_o),
        .drain      (drain_bus.buffer)
    );

    sb_drain sb_drain_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .drain_en_i  (drain_en),
        .drain_gap_i (drain_gap),
        .entry       (drain_bus.drain),
        .mem_req_o   (mem_req_o),
        .mem_ack_i   (mem_ack_i),
        .mem_addr_o  (mem_addr_o),
        .mem_data_o  (mem_data_o),
        .mem_strb_o  (mem_strb_o)
    );

    sb_config sb_config_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_we_i    (cfg_we_i),
        .cfg_wdata_i (cfg_wdata_i),
        .sb_count_i  (sb_count_o),
        .cfg_rdata_o (cfg_rdata_o),
        .drain_en_o  (drain_en),
        .drain_gap_o (drain_gap)
    );

endmodule

// ==== test/lsu_store_checker.sv ====
`timescale 1ns/1ps

module lsu_store_checker (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        st_ready_i,
    input  logic [sb_pkg::SB_CNT_W-1:0] sb_count_i,
    input  logic                        mem_req_i,
    input  logic                        mem_ack_i,
    input  logic [sb_pkg::ADDR_W-1:0]   mem_addr_i,
    input  logic [sb_pkg::DATA_W-1:0]   mem_data_i,
    input  logic [sb_pkg::STRB_W-1:0]   mem_strb_i,
    input  logic                        cfg_we_i,
    input  logic [mem_pkg::CFG_W-1:0]   cfg_wdata_i,
    input  logic [mem_pkg::CFG_W-1:0]   cfg_rdata_i,
    input  int                          exp_cnt_i,
    input  sb_pkg::sb_entry_t           pop_entry_i,
    input  logic                        pop_ok_i,
    input  int                          test_id_i,
    output int                          errors_o,
    output logic                        done_o
);

    int                        test_errors;
    int                        tests_passed;
    int                        tests_failed;
    int                        cur_id;
    int                        since_ack;
    int                        gap_need;
    logic                      gap_armed;
    logic                      prev_req;
    logic                      prev_ack;
    // register shadow, en_old is the enable seen at the previous edge
    logic                      en_s;
    logic                      en_old;
    logic [mem_pkg::GAP_W-1:0] gap_s;
    logic [mem_pkg::CFG_W-1:0] exp_rd;
    logic [sb_pkg::ADDR_W-1:0] prev_addr;
    logic [sb_pkg::DATA_W-1:0] prev_data;
    logic [sb_pkg::STRB_W-1:0] prev_strb;

    function automatic string test_name(input int id);
        case (id)
            1: return "in-order writes";
            2: return "back-pressure";
            3: return "flush keeps committed stores";
            4: return "drain enable";
            5: return "drain gap";
            default: return "four-phase protocol";
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            test_errors++;
            errors_o++;
        end
    endtask

    task automatic report_problem(input string what);
        $display("Error at %0t ns: %s", $time, what);
        test_errors++;
        errors_o++;
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            errors_o     = 0;
            done_o       = 1'b0;
            test_errors  = 0;
            tests_passed = 0;
            tests_failed = 0;
            cur_id       = 0;
            gap_armed    = 1'b0;
            since_ack    = 0;
            gap_need     = 0;
            prev_req     = 1'b0;
            prev_ack     = 1'b0;
            en_s         = 1'b1;
            en_old       = 1'b1;
            gap_s        = '0;
        end else begin
            check_value("sb_count_o", 32'(sb_count_i), 32'(exp_cnt_i));
            check_value("st_ready_o", 32'(st_ready_i),
                        (exp_cnt_i < sb_pkg::SB_SIZE) ? 32'd1 : 32'd0);
            exp_rd = '0;
            exp_rd[mem_pkg::CFG_EN_BIT] = en_s;
            exp_rd[mem_pkg::CFG_GAP_LSB +: mem_pkg::GAP_W] = gap_s;
            exp_rd[mem_pkg::CFG_CNT_LSB +: sb_pkg::SB_CNT_W] = exp_cnt_i[sb_pkg::SB_CNT_W-1:0];
            check_value("cfg_rdata_o", 32'(cfg_rdata_i), 32'(exp_rd));

            if (gap_armed) begin
                since_ack++;
            end
            // start of a memory write
            if (mem_req_i && !prev_req) begin
                if (!en_old) begin
                    report_problem("mem_req_o rose while drain was disabled");
                end
                if (prev_ack) begin
                    report_problem("mem_req_o rose while mem_ack_i was still high");
                end
                if (gap_armed && since_ack < gap_need) begin
                    report_problem("idle gap between writes shorter than configured");
                end
                gap_armed = 1'b0;
                if (!pop_ok_i) begin
                    report_problem("memory write without a committed store");
                end else begin
                    check_value("mem_addr_o", mem_addr_i, pop_entry_i.addr);
                    check_value("mem_data_o", mem_data_i, pop_entry_i.data);
                    check_value("mem_strb_o", 32'(mem_strb_i), 32'(pop_entry_i.strb));
                end
            end
            if (prev_req && mem_req_i) begin
                check_value("mem_addr_o", mem_addr_i, prev_addr);
                check_value("mem_data_o", mem_data_i, prev_data);
                check_value("mem_strb_o", 32'(mem_strb_i), 32'(prev_strb));
            end
            if (prev_req && !mem_req_i && !prev_ack) begin
                report_problem("mem_req_o dropped before mem_ack_i was seen");
            end
            // gap is counted from the release of ack
            if (prev_ack && !mem_ack_i) begin
                gap_armed = 1'b1;
                since_ack = 0;
                gap_need  = 32'(gap_s) + 1;
            end

            en_old = en_s;
            if (cfg_we_i) begin
                en_s  = cfg_wdata_i[mem_pkg::CFG_EN_BIT];
                gap_s = cfg_wdata_i[mem_pkg::CFG_GAP_LSB +: mem_pkg::GAP_W];
            end
            prev_req  = mem_req_i;
            prev_ack  = mem_ack_i;
            prev_addr = mem_addr_i;
            prev_data = mem_data_i;
            prev_strb = mem_strb_i;

            if (test_id_i != cur_id) begin
                if (cur_id != 0) begin
                    $display("test %0d (%s): %s, %0d errors", cur_id, test_name(cur_id),
                             (test_errors == 0) ? "pass" : "fail", test_errors);
                    if (test_errors == 0) begin
                        tests_passed++;
                    end else begin
                        tests_failed++;
                    end
                end
                cur_id      = test_id_i;
                test_errors = 0;
                // ids past the last test close the run
                if (cur_id > 6) begin
                    $display("%0d tests: %0d passed, %0d failed, %0d errors",
                             tests_passed + tests_failed, tests_passed, tests_failed, errors_o);
                    done_o = 1'b1;
                end
            end
        end
    end

endmodule

// ==== test/lsu_store_tb.sv ====
`timescale 1ns/1ps

module lsu_store_tb;

    localparam int STIM_CYCLES = 250 + 60 + 250 + 160 + 240 + 100;
    localparam int CYCLE_LIMIT = STIM_CYCLES * 4 + 200;

    logic                        clk = 1'b0;
    logic                        rst_n;
    logic                        flush_i;
    logic                        commit_i;
    logic                        st_valid_i;
    logic                        st_ready_o;
    logic [sb_pkg::ADDR_W-1:0]   st_addr_i;
    logic [sb_pkg::DATA_W-1:0]   st_data_i;
    logic [sb_pkg::STRB_W-1:0]   st_strb_i;
    logic                        mem_req_o;
    logic                        mem_ack_i;
    logic [sb_pkg::ADDR_W-1:0]   mem_addr_o;
    logic [sb_pkg::DATA_W-1:0]   mem_data_o;
    logic [sb_pkg::STRB_W-1:0]   mem_strb_o;
    logic                        cfg_we_i;
    logic [mem_pkg::CFG_W-1:0]   cfg_wdata_i;
    logic [mem_pkg::CFG_W-1:0]   cfg_rdata_o;
    logic [sb_pkg::SB_CNT_W-1:0] sb_count_o;

    // reference model holds the oldest store first
    // the first cmt_m entries are committed
    sb_pkg::sb_entry_t         model_q[$];
    sb_pkg::sb_entry_t         pop_entry;
    logic                      pop_ok;
    logic                      prev_req;
    logic                      cfg_pending;
    logic [mem_pkg::CFG_W-1:0] cfg_word;
    int                        cmt_m;
    int                        exp_cnt;
    int                        test_id;
    int                        ack_wait;
    int                        rel_wait;
    int                        cycle_cnt = 0;
    int                        checker_errors;
    logic                      checker_done;
    integer                    seed;

    always #4 clk = ~clk;

    lsu_store_top lsu_store_top_inst (
        .clk(clk), .rst_n(rst_n), .flush_i(flush_i), .commit_i(commit_i),
        .st_valid_i(st_valid_i), .st_ready_o(st_ready_o), .st_addr_i(st_addr_i),
        .st_data_i(st_data_i), .st_strb_i(st_strb_i), .mem_req_o(mem_req_o),
        .mem_ack_i(mem_ack_i), .mem_addr_o(mem_addr_o), .mem_data_o(mem_data_o),
        .mem_strb_o(mem_strb_o), .cfg_we_i(cfg_we_i), .cfg_wdata_i(cfg_wdata_i),
        .cfg_rdata_o(cfg_rdata_o), .sb_count_o(sb_count_o)
    );

    lsu_store_checker lsu_store_checker_inst (
        .clk(clk), .rst_n(rst_n), .st_ready_i(st_ready_o), .sb_count_i(sb_count_o),
        .mem_req_i(mem_req_o), .mem_ack_i(mem_ack_i), .mem_addr_i(mem_addr_o),
        .mem_data_i(mem_data_o), .mem_strb_i(mem_strb_o), .cfg_we_i(cfg_we_i),
        .cfg_wdata_i(cfg_wdata_i), .cfg_rdata_i(cfg_rdata_o), .exp_cnt_i(exp_cnt),
        .pop_entry_i(pop_entry), .pop_ok_i(pop_ok), .test_id_i(test_id),
        .errors_o(checker_errors), .done_o(checker_done)
    );

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("Timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    function automatic int roll();
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % 100;
    endfunction

    // applies the edge just past while inputs still hold the values it sampled
    task automatic update_model();
        sb_pkg::sb_entry_t e;
        int                cnt_pre;
        int                cmt_pre;
        cnt_pre = model_q.size();
        cmt_pre = cmt_m;
        // req rising means the oldest committed store left at this edge
        if (mem_req_o && !prev_req) begin
            pop_ok = (cmt_m > 0);
            if (cmt_m > 0) begin
                pop_entry = model_q.pop_front();
                cmt_m--;
            end
        end
        prev_req = mem_req_o;
        if (commit_i && !flush_i && cnt_pre > cmt_pre) begin
            cmt_m++;
        end
        if (flush_i) begin
            while (model_q.size() > cmt_m) begin
                model_q.delete(model_q.size() - 1);
            end
        end else if (st_valid_i && cnt_pre < sb_pkg::SB_SIZE) begin
            e.addr   = st_addr_i;
            e.data   = st_data_i;
            e.strb   = st_strb_i;
            e.valid  = 1'b1;
            e.commit = 1'b0;
            model_q.push_back(e);
        end
        exp_cnt = model_q.size();
    endtask

    // memory side of the four-phase handshake
    // random delays before ack rises and before it is released
    task automatic answer_memory();
        if (mem_req_o && !mem_ack_i) begin
            if (ack_wait == 0) begin
                mem_ack_i = 1'b1;
                rel_wait  = roll() % 4;
            end else begin
                ack_wait--;
            end
        end else if (!mem_req_o && mem_ack_i) begin
            if (rel_wait == 0) begin
                mem_ack_i = 1'b0;
                ack_wait  = roll() % 8;
            end else begin
                rel_wait--;
            end
        end
    endtask

    task automatic step(input int p_store, input int p_commit, input int p_flush);
        logic [31:0] r;
        @(negedge clk);
        update_model();
        answer_memory();
        cfg_we_i = cfg_pending;
        if (cfg_pending) begin
            cfg_wdata_i = cfg_word;
        end
        cfg_pending = 1'b0;
        flush_i    = (roll() < p_flush);
        commit_i   = !flush_i && (cmt_m < exp_cnt) && (roll() < p_commit);
        st_valid_i = (roll() < p_store);
        st_addr_i  = $random(seed);
        st_data_i  = $random(seed);
        r          = $random(seed);
        st_strb_i  = r[sb_pkg::STRB_W-1:0];
    endtask

    task automatic run_cycles(input int n, input int p_store, input int p_commit,
                              input int p_flush);
        repeat (n) begin
            step(p_store, p_commit, p_flush);
        end
    endtask

    // random filler in the unused bits of the word
    task automatic write_cfg(input logic en, input logic [mem_pkg::GAP_W-1:0] gap);
        logic [31:0] r;
        r        = $random(seed);
        cfg_word = r[mem_pkg::CFG_W-1:0];
        cfg_word[mem_pkg::CFG_EN_BIT] = en;
        cfg_word[mem_pkg::CFG_GAP_LSB +: mem_pkg::GAP_W] = gap;
        cfg_pending = 1'b1;
        step(0, 0, 0);
    endtask

    initial begin
        int gap;
        rst_n       = 1'b0;
        flush_i     = 1'b0;
        commit_i    = 1'b0;
        st_valid_i  = 1'b0;
        st_addr_i   = '0;
        st_data_i   = '0;
        st_strb_i   = '0;
        mem_ack_i   = 1'b0;
        cfg_we_i    = 1'b0;
        cfg_wdata_i = '0;
        seed        = 32'h2b7e_caca;
        pop_entry   = '0;
        pop_ok      = 1'b0;
        prev_req    = 1'b0;
        cfg_pending = 1'b0;
        cfg_word    = '0;
        cmt_m       = 0;
        exp_cnt     = 0;
        test_id     = 0;
        ack_wait    = 0;
        rel_wait    = 0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        test_id = 1;
        run_cycles(250, 60, 40, 0);
        // drain off lets the buffer fill
        test_id = 2;
        write_cfg(1'b0, 4'd0);
        run_cycles(59, 70, 20, 0);
        test_id = 3;
        write_cfg(1'b1, 4'd0);
        run_cycles(249, 60, 30, 5);
        test_id = 4;
        write_cfg(1'b0, 4'd1);
        run_cycles(79, 50, 40, 0);
        write_cfg(1'b1, 4'd1);
        run_cycles(79, 10, 10, 0);
        test_id = 5;
        repeat (4) begin
            gap = roll() % 15 + 1;
            write_cfg(1'b1, gap[mem_pkg::GAP_W-1:0]);
            run_cycles(59, 60, 40, 2);
        end
        test_id = 6;
        write_cfg(1'b1, 4'd0);
        run_cycles(99, 60, 40, 5);
        // retire whatever is left and let it reach memory
        while (exp_cnt != 0 || mem_req_o || mem_ack_i) begin
            step(0, 100, 0);
        end
        test_id = 7;
        while (!checker_done) begin
            @(negedge clk);
        end
        if (checker_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== lsu_store_top.f ====
verilog/sb_pkg.sv
verilog/mem_pkg.sv
verilog/sb_drain_if.sv
verilog/store_buffer.sv
verilog/sb_drain.sv
verilog/sb_config.sv
verilog/lsu_store_top.sv
test/lsu_store_checker.sv
test/lsu_store_tb.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --top-module lsu_store_tb -f lsu_store_top.f -Mdir obj_dir -o sim
	./obj_dir/sim > $(LOG) 2>&1; cat $(LOG)
	@! grep -q "Test failed" $(LOG) && grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
